/* Bender.yml */
package:
  name: engine

sources:
  - design/engine_pkg.sv
  - design/credit_fifo.sv
  - design/operand_fetch.sv
  - design/reduce_unit.sv
  - design/average_divider.sv
  - design/result_sender.sv
  - design/engine.sv
  - target: test
    files:
      - testbench/engine_assert.sv
      - testbench/engine_tb.sv

/* design/average_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module average_divider import engine_pkg::*; (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           part_valid,
	input  partial_t       part,
	output logic           stall,
	output logic           res_valid,
	output engine_result_t res,
	input  logic           res_stall
);

	logic busy;
	logic [DIV_STEP_W-1:0] step;
	logic [ACC_W-1:0] quo;
	logic [COUNT_W-1:0] rem;
	logic [COUNT_W-1:0] divisor;
	logic neg;
	logic [COUNT_W:0] shifted;
	logic [COUNT_W+1:0] trial;
	logic ge;
	logic iterate;
	logic accept;
	logic finish;
	logic res_load;
	logic signed [ACC_W-1:0] direct_val;
	logic signed [ACC_W-1:0] quot_val;

	function automatic logic signed [DATA_W-1:0] sat16(input logic signed [ACC_W-1:0] v);
		if (v > ACC_W'(32767)) begin
			return 16'sh7fff;
		end else if (v < -ACC_W'(32768)) begin
			return 16'sh8000;
		end
		return v[DATA_W-1:0];
	endfunction

	assign stall = busy || (res_valid && res_stall); // held while dividing.
	assign accept = part_valid && !stall;
	assign iterate = busy && (step != DIV_STEP_W'(ACC_W));
	assign finish = busy && (step == DIV_STEP_W'(ACC_W)) && !(res_valid && res_stall);
	assign res_load = (accept && part.op != op_avepool) || finish;

	always_comb begin
		shifted = {rem, quo[ACC_W-1]};
		trial = {1'b0, shifted} - {2'b00, divisor};
		ge = !trial[COUNT_W+1];
		direct_val = (part.op == op_conv) ? ($signed(part.acc) >>> 8) : $signed(part.acc);
		quot_val = neg ? -$signed(quo) : $signed(quo); // truncates toward zero.
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			step <= '0;
			res_valid <= 1'b0;
		end else begin
			if (accept && part.op == op_avepool) begin
				busy <= 1'b1;
				step <= '0;
			end else if (iterate) begin
				step <= step + DIV_STEP_W'(1);
			end else if (finish) begin
				busy <= 1'b0;
			end
			if (res_load) begin
				res_valid <= 1'b1;
			end else if (!res_stall) begin
				res_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			quo <= part.acc[ACC_W-1] ? -part.acc : part.acc; // magnitude.
			rem <= '0;
			divisor <= part.count;
			neg <= part.acc[ACC_W-1];
		end else if (iterate) begin
			quo <= {quo[ACC_W-2:0], ge};
			rem <= ge ? trial[COUNT_W-1:0] : shifted[COUNT_W-1:0];
		end
		if (res_load) begin
			res.op <= finish ? op_avepool : part.op;
			res.value <= sat16(finish ? quot_val : direct_val);
		end
	end

endmodule

`default_nettype wire

/* design/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter type payload_t = logic,
	parameter int depth = 2
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty,
	output logic     full
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] occupancy;

	assign empty = (occupancy == '0);
	assign full = (occupancy == cnt_w'(depth));
	assign pop_data = mem[rd_ptr]; // head is visible before the pop.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
			end
			if (push && !pop) begin
				occupancy <= occupancy + cnt_w'(1);
			end else if (pop && !push) begin
				occupancy <= occupancy - cnt_w'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

`default_nettype wire

/* design/engine.sv */
`timescale 1ns/1ps
`default_nettype none

module engine import engine_pkg::*; (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           cmd_valid,
	input  engine_cmd_t    cmd,
	output logic           cmd_credit,
	input  logic           data_valid,
	input  operand_t       data,
	output logic           data_credit,
	input  logic           weight_valid,
	input  operand_t       weight,
	output logic           weight_credit,
	output logic           res_valid,
	output engine_result_t res,
	input  logic           res_credit
);

	logic pair_valid;
	pair_t pair;
	logic reduce_stall;
	logic part_valid;
	partial_t part;
	logic div_stall;
	logic div_valid;
	engine_result_t div_res;
	logic send_stall;

	operand_fetch i_operand_fetch (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.cmd_credit   (cmd_credit),
		.data_valid   (data_valid),
		.data         (data),
		.data_credit  (data_credit),
		.weight_valid (weight_valid),
		.weight       (weight),
		.weight_credit(weight_credit),
		.pair_valid   (pair_valid),
		.pair         (pair),
		.stall        (reduce_stall)
	);

	reduce_unit i_reduce_unit (
		.clk       (clk),
		.arst_n    (arst_n),
		.pair_valid(pair_valid),
		.pair      (pair),
		.stall     (reduce_stall),
		.part_valid(part_valid),
		.part      (part),
		.part_stall(div_stall)
	);

	average_divider i_average_divider (
		.clk       (clk),
		.arst_n    (arst_n),
		.part_valid(part_valid),
		.part      (part),
		.stall     (div_stall),
		.res_valid (div_valid),
		.res       (div_res),
		.res_stall (send_stall)
	);

	result_sender i_result_sender (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (div_valid),
		.in_res    (div_res),
		.in_stall  (send_stall),
		.res_valid (res_valid),
		.res       (res),
		.res_credit(res_credit)
	);

endmodule

`default_nettype wire

/* design/engine_pkg.sv */
`default_nettype none

package engine_pkg;

	// element and accumulator widths.
	localparam int COUNT_W = 12;
	localparam int DATA_W = 16;
	localparam int ACC_W = 40;

	// credits held by each source after reset.
	localparam int OPERAND_CREDITS = 4;
	localparam int RESULT_CREDITS = 2;

	// derived counter widths.
	localparam int RES_CREDIT_W = $clog2(RESULT_CREDITS + 1);
	localparam int DIV_STEP_W = $clog2(ACC_W + 1);

	typedef enum logic [1:0] {
		op_conv,
		op_maxpool,
		op_avepool
	} engine_op_e;

	typedef struct packed {
		engine_op_e op;
		logic [COUNT_W-1:0] count; // 1 to 4095.
	} engine_cmd_t;

	typedef struct packed {
		logic signed [DATA_W-1:0] value; // Q8.8.
	} operand_t;

	typedef struct packed {
		engine_op_e op;
		logic signed [DATA_W-1:0] data;
		logic signed [DATA_W-1:0] weight; // zero for pooling.
		logic last;
	} pair_t;

	typedef struct packed {
		engine_op_e op;
		logic signed [ACC_W-1:0] acc;
		logic [COUNT_W-1:0] count;
	} partial_t;

	typedef struct packed {
		engine_op_e op;
		logic signed [DATA_W-1:0] value;
	} engine_result_t;

endpackage

`default_nettype wire

/* design/operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import engine_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        cmd_valid,
	input  engine_cmd_t cmd,
	output logic        cmd_credit,
	input  logic        data_valid,
	input  operand_t    data,
	output logic        data_credit,
	input  logic        weight_valid,
	input  operand_t    weight,
	output logic        weight_credit,
	output logic        pair_valid,
	output pair_t       pair,
	input  logic        stall
);

	logic data_pop;
	logic weight_pop;
	logic data_empty;
	logic weight_empty;
	operand_t data_head;
	operand_t weight_head;
	logic active;
	engine_op_e op;
	logic [COUNT_W-1:0] remaining;
	logic is_conv;
	logic is_last;
	logic fire;
	logic last_issued;

	credit_fifo #(.payload_t(operand_t), .depth(OPERAND_CREDITS)) i_data_fifo (
		.clk      (clk),
		.arst_n   (arst_n),
		.push     (data_valid),
		.push_data(data),
		.pop      (data_pop),
		.pop_data (data_head),
		.empty    (data_empty),
		.full     ()
	);

	credit_fifo #(.payload_t(operand_t), .depth(OPERAND_CREDITS)) i_weight_fifo (
		.clk      (clk),
		.arst_n   (arst_n),
		.push     (weight_valid),
		.push_data(weight),
		.pop      (weight_pop),
		.pop_data (weight_head),
		.empty    (weight_empty),
		.full     ()
	);

	assign is_conv = (op == op_conv);
	assign is_last = (remaining == COUNT_W'(1));
	// pooling needs only the data buffer.
	assign fire = active && !data_empty && (!is_conv || !weight_empty) && (!pair_valid || !stall);
	assign data_pop = fire;
	assign weight_pop = fire && is_conv;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			op <= op_conv;
			remaining <= '0;
			pair_valid <= 1'b0;
			last_issued <= 1'b0;
			cmd_credit <= 1'b0;
			data_credit <= 1'b0;
			weight_credit <= 1'b0;
		end else begin
			data_credit <= data_pop;
			weight_credit <= weight_pop;
			last_issued <= fire && is_last;
			cmd_credit <= last_issued; // one cycle after the last pair shows.
			if (cmd_valid) begin
				active <= 1'b1;
				op <= cmd.op;
				remaining <= cmd.count;
			end else if (fire) begin
				remaining <= remaining - COUNT_W'(1);
				if (is_last) begin
					active <= 1'b0;
				end
			end
			if (fire) begin
				pair_valid <= 1'b1;
			end else if (!stall) begin
				pair_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			pair.op <= op;
			pair.data <= data_head.value;
			pair.weight <= is_conv ? weight_head.value : '0;
			pair.last <= is_last;
		end
	end

endmodule

`default_nettype wire

/* design/reduce_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module reduce_unit import engine_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     pair_valid,
	input  pair_t    pair,
	output logic     stall,
	output logic     part_valid,
	output partial_t part,
	input  logic     part_stall
);

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_next;
	logic signed [ACC_W-1:0] data_ext;
	logic signed [ACC_W-1:0] prod_ext;
	logic signed [2*DATA_W-1:0] prod;
	logic [COUNT_W-1:0] elem_cnt;
	logic [COUNT_W-1:0] elem_cnt_next;
	logic accept;

	assign stall = part_valid && part_stall;
	assign accept = pair_valid && !stall;
	assign elem_cnt_next = elem_cnt + COUNT_W'(1);

	always_comb begin
		prod = $signed(pair.data) * $signed(pair.weight); // Q16.16 product.
		prod_ext = prod;
		data_ext = $signed(pair.data);
		case (pair.op)
			op_conv: begin
				acc_next = acc + prod_ext;
			end
			op_maxpool: begin
				// first element seeds the maximum.
				if (elem_cnt == '0 || data_ext > acc) begin
					acc_next = data_ext;
				end else begin
					acc_next = acc;
				end
			end
			default: begin
				acc_next = acc + data_ext;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
			elem_cnt <= '0;
			part_valid <= 1'b0;
		end else begin
			if (accept) begin
				if (pair.last) begin
					acc <= '0; // ready for the next command.
					elem_cnt <= '0;
				end else begin
					acc <= acc_next;
					elem_cnt <= elem_cnt_next;
				end
			end
			if (accept && pair.last) begin
				part_valid <= 1'b1;
			end else if (!part_stall) begin
				part_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && pair.last) begin
			part.op <= pair.op;
			part.acc <= acc_next;
			part.count <= elem_cnt_next;
		end
	end

endmodule

`default_nettype wire

/* design/result_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module result_sender import engine_pkg::*; (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           in_valid,
	input  engine_result_t in_res,
	output logic           in_stall,
	output logic           res_valid,
	output engine_result_t res,
	input  logic           res_credit
);

	logic push;
	logic pop;
	logic empty;
	logic full;
	engine_result_t head;
	logic [RES_CREDIT_W-1:0] credits;

	assign in_stall = full;
	assign push = in_valid && !full;
	assign pop = !empty && (credits != '0); // send only under a consumer credit.

	credit_fifo #(.payload_t(engine_result_t), .depth(RESULT_CREDITS)) i_res_fifo (
		.clk      (clk),
		.arst_n   (arst_n),
		.push     (push),
		.push_data(in_res),
		.pop      (pop),
		.pop_data (head),
		.empty    (empty),
		.full     (full)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= RES_CREDIT_W'(RESULT_CREDITS);
			res_valid <= 1'b0;
		end else begin
			res_valid <= pop;
			if (pop && !res_credit) begin
				credits <= credits - RES_CREDIT_W'(1);
			end else if (!pop && res_credit) begin
				credits <= credits + RES_CREDIT_W'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			res <= head;
		end
	end

endmodule

`default_nettype wire

/* engine.f */
design/engine_pkg.sv
design/credit_fifo.sv
design/operand_fetch.sv
design/reduce_unit.sv
design/average_divider.sv
design/result_sender.sv
design/engine.sv
testbench/engine_assert.sv
testbench/engine_tb.sv

/* testbench/engine_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module engine_assert import engine_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input logic        cmd_valid,
	input engine_cmd_t cmd,
	input logic        data_valid,
	input logic        data_full,
	input logic        weight_valid,
	input logic        weight_full,
	input logic        data_credit,
	input logic        res_valid,
	input logic        res_credit
);

	int fail_cnt = 0;
	logic [3:0] res_credits; // consumer credits seen at the port.
	logic [7:0] credits_since_beat;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_credits <= 4'(RESULT_CREDITS);
			credits_since_beat <= '0;
		end else begin
			res_credits <= res_credits - 4'(res_valid) + 4'(res_credit);
			if (data_valid) begin
				credits_since_beat <= '0;
			end else if (data_credit) begin
				credits_since_beat <= credits_since_beat + 8'd1;
			end
		end
	end

	data_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		data_valid |-> !data_full)
		else begin
			fail_cnt++;
			$error("data beat pushed into a full buffer");
		end

	weight_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		weight_valid |-> !weight_full)
		else begin
			fail_cnt++;
			$error("weight beat pushed into a full buffer");
		end

	res_under_credit: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> res_credits != '0)
		else begin
			fail_cnt++;
			$error("result sent without a consumer credit");
		end

	cmd_count_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid |-> cmd.count != '0)
		else begin
			fail_cnt++;
			$error("command with a zero element count");
		end

	data_credit_bounded: assert property (@(posedge clk) disable iff (!arst_n)
		credits_since_beat <= 8'(OPERAND_CREDITS))
		else begin
			fail_cnt++;
			$error("data credits returned without data beats");
		end

endmodule

`default_nettype wire

/* testbench/engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module engine_tb import engine_pkg::*; ();

	logic clk;
	logic arst_n;
	logic cmd_valid;
	engine_cmd_t cmd;
	logic cmd_credit;
	logic data_valid;
	operand_t data;
	logic data_credit;
	logic weight_valid;
	operand_t weight;
	logic weight_credit;
	logic res_valid;
	engine_result_t res;
	logic res_credit;

	engine_cmd_t cmd_q[$];
	logic [DATA_W-1:0] data_q[$];
	logic [DATA_W-1:0] weight_q[$];
	engine_result_t want_q[$]; // model results in command order.
	int cmd_credits;
	int data_credits;
	int weight_credits;
	int owed; // results not yet credited back.
	int granted;
	int idle_pct;
	int cmd_idle_pct;
	int return_pct;
	int errors;
	int results;
	int test_cmds;
	int test_start_errors;
	int cycle;
	int cycle_limit;

	engine i_engine (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.cmd_credit   (cmd_credit),
		.data_valid   (data_valid),
		.data         (data),
		.data_credit  (data_credit),
		.weight_valid (weight_valid),
		.weight       (weight),
		.weight_credit(weight_credit),
		.res_valid    (res_valid),
		.res          (res),
		.res_credit   (res_credit)
	);

	bind engine engine_assert i_engine_assert (
		.clk         (clk),
		.arst_n      (arst_n),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.data_valid  (data_valid),
		.data_full   (i_operand_fetch.i_data_fifo.full),
		.weight_valid(weight_valid),
		.weight_full (i_operand_fetch.i_weight_fifo.full),
		.data_credit (data_credit),
		.res_valid   (res_valid),
		.res_credit  (res_credit)
	);

	always #50 clk = ~clk; // 100 ns period.

	function automatic int rand_range(input int lo, input int hi);
		int unsigned span;
		span = hi - lo + 1;
		return lo + int'($urandom % span);
	endfunction

	function automatic logic signed [DATA_W-1:0] saturate(input longint v);
		if (v > 32767) begin
			return 16'sh7fff;
		end else if (v < -32768) begin
			return 16'sh8000;
		end
		return v[DATA_W-1:0];
	endfunction

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] want);
		if (got !== want) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
			errors++;
		end
	endtask

	// queues one command with operands drawn from the given ranges.
	task automatic queue_command(input engine_op_e op, input int count,
			input int dlo, input int dhi, input int wlo, input int whi);
		engine_cmd_t c;
		engine_result_t r;
		logic signed [DATA_W-1:0] d;
		logic signed [DATA_W-1:0] w;
		longint sum;
		longint best;
		int i;
		sum = 0;
		best = 0;
		for (i = 0; i < count; i++) begin
			d = DATA_W'(rand_range(dlo, dhi));
			data_q.push_back(d);
			if (op == op_conv) begin
				w = DATA_W'(rand_range(wlo, whi));
				weight_q.push_back(w);
				sum += longint'(d) * longint'(w);
			end else begin
				sum += longint'(d);
				if (i == 0 || longint'(d) > best) begin
					best = d;
				end
			end
		end
		r.op = op;
		case (op)
			op_conv: r.value = saturate(sum >>> 8); // Q16.16 back to Q8.8.
			op_maxpool: r.value = best[DATA_W-1:0];
			default: r.value = saturate(sum / count); // truncates toward zero.
		endcase
		want_q.push_back(r);
		c.op = op;
		c.count = COUNT_W'(count);
		cmd_q.push_back(c);
		test_cmds++;
		cycle_limit += 2 * (count + 50);
	endtask

	task automatic queue_random(input engine_op_e op);
		int count;
		int dbits;
		int wbits;
		count = rand_range(1, 200);
		dbits = rand_range(4, 16);
		wbits = rand_range(4, 16);
		queue_command(op, count, -(1 << (dbits - 1)), (1 << (dbits - 1)) - 1,
			-(1 << (wbits - 1)), (1 << (wbits - 1)) - 1);
	endtask

	task automatic begin_test(input int cmd_gap, input int src_gap, input int ret);
		cmd_idle_pct = cmd_gap;
		idle_pct = src_gap;
		return_pct = ret;
		test_cmds = 0;
		test_start_errors = errors;
	endtask

	task automatic finish_test(input int num, input string name);
		while (want_q.size() != 0) begin
			@(posedge clk);
		end
		$display("test %0d %s: %0d commands, %0d errors", num, name, test_cmds,
			errors - test_start_errors);
	endtask

	// command, data and weight sources.
	always @(negedge clk) begin
		if (!arst_n) begin
			cmd_credits = 1;
			data_credits = OPERAND_CREDITS;
			weight_credits = OPERAND_CREDITS;
			cmd_valid = 1'b0;
			data_valid = 1'b0;
			weight_valid = 1'b0;
		end else begin
			cmd_credits += cmd_credit;
			data_credits += data_credit;
			weight_credits += weight_credit;
			cmd_valid = cmd_credits > 0 && cmd_q.size() > 0 && rand_range(0, 99) >= cmd_idle_pct;
			if (cmd_valid) begin
				cmd = cmd_q.pop_front();
				cmd_credits--;
			end
			data_valid = data_credits > 0 && data_q.size() > 0 && rand_range(0, 99) >= idle_pct;
			if (data_valid) begin
				data.value = data_q.pop_front();
				data_credits--;
			end
			weight_valid = weight_credits > 0 && weight_q.size() > 0
				&& rand_range(0, 99) >= idle_pct;
			if (weight_valid) begin
				weight.value = weight_q.pop_front();
				weight_credits--;
			end
		end
	end

	// result sink and checker.
	always @(negedge clk) begin
		engine_result_t want;
		if (!arst_n) begin
			res_credit = 1'b0;
			owed = 0;
			granted = RESULT_CREDITS;
		end else begin
			if (res_valid) begin
				if (granted == 0) begin
					$display("result sent while the consumer had granted no credit");
					errors++;
				end
				granted--;
				owed++;
				if (want_q.size() == 0) begin
					$display("result arrived with no command outstanding");
					errors++;
				end else begin
					want = want_q.pop_front();
					check_value("res.op", res.op, want.op);
					check_value("res.value", res.value, want.value);
					results++;
				end
			end
			res_credit = owed > 0 && rand_range(0, 99) < return_pct;
			if (res_credit) begin
				owed--;
				granted++;
			end
		end
	end

	always @(posedge clk) begin
		cycle++;
		if (cycle > cycle_limit) begin
			$display("timeout after %0d cycles with %0d results still missing", cycle,
				want_q.size());
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		data_valid = 1'b0;
		data = '0;
		weight_valid = 1'b0;
		weight = '0;
		res_credit = 1'b0;
		errors = 0;
		results = 0;
		cycle = 0;
		cycle_limit = 100; // reset and final drain.
		void'($urandom(32'h210c_8af7));
		begin_test(20, 20, 80);
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		queue_command(op_conv, 8, 32767, 32767, 32767, 32767);
		queue_command(op_conv, 8, 32767, 32767, -32768, -32768);
		queue_command(op_conv, 1, -256, 255, -256, 255);
		repeat (10) queue_random(op_conv);
		finish_test(1, "convolution dot products");

		begin_test(20, 20, 80);
		queue_command(op_maxpool, 1, -32768, 32767, 0, 0);
		queue_command(op_maxpool, 40, -32768, -1, 0, 0);
		repeat (8) queue_random(op_maxpool);
		finish_test(2, "max pooling");

		begin_test(20, 20, 80);
		queue_command(op_avepool, 9, -32768, 32767, 0, 0);
		queue_command(op_avepool, 169, -32768, 32767, 0, 0);
		queue_command(op_avepool, 169, -32768, -1, 0, 0);
		queue_command(op_avepool, 9, -300, 100, 0, 0);
		repeat (6) queue_random(op_avepool);
		finish_test(3, "average pooling");

		begin_test(10, 10, 3); // sink holds its credits for long stretches.
		repeat (12) queue_random(engine_op_e'(rand_range(0, 2)));
		finish_test(4, "result back-pressure");

		begin_test(0, 0, 90);
		repeat (16) queue_random(engine_op_e'(rand_range(0, 2)));
		finish_test(5, "mixed back-to-back commands");

		repeat (20) @(posedge clk);
		errors += i_engine.i_engine_assert.fail_cnt;
		$display("5 tests, %0d results checked, %0d errors", results, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
